// ==== source/isa_pkg.sv ====
package isa_pkg;

  typedef logic [31:0] word_t;     // data or address word
  typedef logic [4:0]  reg_idx_t;  // gpr number

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
    OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
    OP_ADDIU   = 6'h09, OP_SLTI   = 6'h0a, OP_SLTIU = 6'h0b, OP_ANDI  = 6'h0c,
    OP_ORI     = 6'h0d, OP_XORI   = 6'h0e, OP_LUI   = 6'h0f,
    OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
    OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    F_SLL  = 6'h00, F_SRL  = 6'h02, F_SRA = 6'h03, F_JR  = 6'h08,
    F_ADDU = 6'h21, F_SUBU = 6'h23, F_AND = 6'h24, F_OR  = 6'h25,
    F_XOR  = 6'h26, F_NOR  = 6'h27, F_SLT = 6'h2a, F_SLTU = 6'h2b
  } funct_e;

  // rt field codes under REGIMM
  localparam reg_idx_t RT_BLTZ = 5'd0;
  localparam reg_idx_t RT_BGEZ = 5'd1;

  typedef struct packed {
    opcode_e    opcode;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [4:0] shamt;
    funct_e     funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_e     opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [25:0] idx;    // word index within 256M region
  } j_fmt_t;

  // same 32 bits seen through each format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } inst_u;

endpackage

// ==== source/pipe_pkg.sv ====
package pipe_pkg;
  import isa_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NORM = 3'd0, BR_JR   = 3'd1, BR_BEQ  = 3'd2, BR_BNE  = 3'd3,
    BR_BLEZ = 3'd4, BR_BLTZ = 3'd5, BR_BGEZ = 3'd6, BR_BGTZ = 3'd7
  } br_type_e;

  typedef enum logic [2:0] {
    MEM_WORD, MEM_UBYTE, MEM_UHALF, MEM_SBYTE, MEM_SHALF
  } mem_op_e;

  typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA31} reg_dst_e;

  typedef enum logic [1:0] {FWD_NONE, FWD_FROM_MEM, FWD_FROM_WB} fwd_sel_e;

  typedef struct packed {
    logic     write_reg;
    logic     write_mem;
    logic     read_mem;
    mem_op_e  mem_op;         // access size and load extension
    alu_op_e  alu_op;
    logic     alu_src_a_pc;   // pc instead of rs
    logic     alu_src_b_imm;  // immediate instead of rt
    logic     imm_zero_ext;   // logical immediates
    reg_dst_e reg_dst;
    br_type_e br_type;
    logic     jump;           // j and jal
    logic     link;           // jal
  } ctrl_t;

  typedef struct packed {
    ctrl_t       ctrl;
    word_t       pc_plus_4;
    word_t       op_a;       // rs from regfile
    word_t       op_b;       // rt from regfile
    logic [25:0] inst_lo;    // rs rt rd shamt or jump index
    word_t       imm;
    word_t       br_off;     // sign extended and shifted by 2
  } id_ex_t;

  typedef struct packed {
    logic       write_reg;
    logic       read_mem;
    mem_op_e    mem_op;
    reg_idx_t   dst;
    word_t      alu_out;
    logic [1:0] addr_lo;     // byte lane of the access
    word_t      st_src;      // forwarded rt of a store
  } ex_mem_t;

  typedef struct packed {
    logic     write_reg;
    reg_idx_t dst;
    word_t    data;
  } mem_wb_t;

  typedef struct packed {
    logic  take;
    word_t target;
  } redirect_t;

  typedef struct packed {
    logic        we;
    logic        re;
    logic [29:0] addr;   // word address
    logic [3:0]  be;
    word_t       wdata;
  } dmem_req_t;

endpackage

// ==== source/fetch_stage.sv ====
module fetch_stage import isa_pkg::*, pipe_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        stall_fd,
  input  redirect_t   redirect,
  output logic [29:0] imem_addr,
  input  word_t       imem_data,
  output inst_u       inst_d,
  output word_t       pc_d
);

  word_t pc_f;      // address of the word on imem_data
  word_t next_pc;
  logic  started;   // low until the first fetch has been issued
  inst_u inst_f;

  always_comb begin
    if (!started)
      next_pc = reset_pc;
    else if (stall_fd)
      next_pc = pc_f;             // re-read same word
    else if (redirect.take)
      next_pc = redirect.target;
    else
      next_pc = pc_f + 32'd4;
  end

  assign imem_addr = next_pc[31:2];

  always_comb begin
    if (stall_fd)
      inst_f = inst_d;            // keep decode word
    else if (!started || redirect.take)
      inst_f = '0;                // squash into sll zero
    else
      inst_f = imem_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_f    <= reset_pc;
      started <= 1'b0;
      inst_d  <= '0;
      pc_d    <= '0;
    end else begin
      pc_f    <= next_pc;
      started <= 1'b1;
      inst_d  <= inst_f;
      if (!stall_fd)
        pc_d <= pc_f;
    end
  end

endmodule

// ==== source/regfile.sv ====
module regfile import isa_pkg::*, pipe_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  reg_idx_t rd_addr_a,
  input  reg_idx_t rd_addr_b,
  output word_t    rd_data_a,
  output word_t    rd_data_b,
  input  mem_wb_t  wb
);

  word_t regs [1:31];   // r0 not stored

  function automatic word_t rd_port(reg_idx_t addr, word_t stored, mem_wb_t wr);
    word_t val;
    if (addr == '0)
      val = '0;
    else if (wr.write_reg && wr.dst == addr)
      val = wr.data;      // write-first bypass
    else
      val = stored;
    return val;
  endfunction

  assign rd_data_a = rd_port(rd_addr_a, regs[rd_addr_a], wb);
  assign rd_data_b = rd_port(rd_addr_b, regs[rd_addr_b], wb);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (wb.write_reg && wb.dst != '0) begin
      regs[wb.dst] <= wb.data;
    end
  end

endmodule

// ==== source/control_decoder.sv ====
module control_decoder import isa_pkg::*, pipe_pkg::*; (
  input  inst_u inst,
  output ctrl_t ctrl
);

  always_comb begin
    ctrl = '0;                            // unknown encodings stay a no-op
    case (inst.r.opcode)
      OP_SPECIAL: begin
        ctrl.write_reg = 1'b1;
        ctrl.reg_dst   = DST_RD;
        case (inst.r.funct)
          F_ADDU:  ctrl.alu_op = ALU_ADD;
          F_SUBU:  ctrl.alu_op = ALU_SUB;
          F_AND:   ctrl.alu_op = ALU_AND;
          F_OR:    ctrl.alu_op = ALU_OR;
          F_XOR:   ctrl.alu_op = ALU_XOR;
          F_NOR:   ctrl.alu_op = ALU_NOR;
          F_SLT:   ctrl.alu_op = ALU_SLT;
          F_SLTU:  ctrl.alu_op = ALU_SLTU;
          F_SLL:   ctrl.alu_op = ALU_SLL;
          F_SRL:   ctrl.alu_op = ALU_SRL;
          F_SRA:   ctrl.alu_op = ALU_SRA;
          F_JR: begin
            ctrl.write_reg = 1'b0;
            ctrl.reg_dst   = DST_RT;
            ctrl.br_type   = BR_JR;
          end
          default: ctrl = '0;
        endcase
      end
      OP_REGIMM: begin
        if (inst.i.rt == RT_BLTZ)
          ctrl.br_type = BR_BLTZ;
        else if (inst.i.rt == RT_BGEZ)
          ctrl.br_type = BR_BGEZ;
      end
      OP_J:    ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump          = 1'b1;
        ctrl.link          = 1'b1;
        ctrl.write_reg     = 1'b1;
        ctrl.reg_dst       = DST_RA31;
        ctrl.alu_src_a_pc  = 1'b1;       // pc + 8 past the delay slot
        ctrl.alu_src_b_imm = 1'b1;
      end
      OP_BEQ:  ctrl.br_type = BR_BEQ;
      OP_BNE:  ctrl.br_type = BR_BNE;
      OP_BLEZ: ctrl.br_type = BR_BLEZ;
      OP_BGTZ: ctrl.br_type = BR_BGTZ;
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        ctrl.write_reg     = 1'b1;
        ctrl.alu_src_b_imm = 1'b1;
        ctrl.imm_zero_ext  = inst.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI};
        case (inst.i.opcode)
          OP_SLTI:  ctrl.alu_op = ALU_SLT;
          OP_SLTIU: ctrl.alu_op = ALU_SLTU;    // sign extended, unsigned compare
          OP_ANDI:  ctrl.alu_op = ALU_AND;
          OP_ORI:   ctrl.alu_op = ALU_OR;
          OP_XORI:  ctrl.alu_op = ALU_XOR;
          OP_LUI:   ctrl.alu_op = ALU_LUI;
          default:  ctrl.alu_op = ALU_ADD;
        endcase
      end
      OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU: begin
        ctrl.write_reg     = 1'b1;
        ctrl.read_mem      = 1'b1;
        ctrl.alu_src_b_imm = 1'b1;         // base + offset
        case (inst.i.opcode)
          OP_LB:   ctrl.mem_op = MEM_SBYTE;
          OP_LBU:  ctrl.mem_op = MEM_UBYTE;
          OP_LH:   ctrl.mem_op = MEM_SHALF;
          OP_LHU:  ctrl.mem_op = MEM_UHALF;
          default: ctrl.mem_op = MEM_WORD;
        endcase
      end
      OP_SW, OP_SH, OP_SB: begin
        ctrl.write_mem     = 1'b1;
        ctrl.alu_src_b_imm = 1'b1;
        if (inst.i.opcode == OP_SB)
          ctrl.mem_op = MEM_UBYTE;
        else if (inst.i.opcode == OP_SH)
          ctrl.mem_op = MEM_UHALF;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

// ==== source/decode_stage.sv ====
module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     stall_fd,
  input  logic     flush_e,
  input  inst_u    inst_d,
  input  word_t    pc_d,
  output reg_idx_t rs_d,
  output reg_idx_t rt_d,
  input  word_t    rd_data_a,
  input  word_t    rd_data_b,
  output id_ex_t   id_ex
);

  ctrl_t  ctrl;
  word_t  imm_ext;
  id_ex_t id_ex_d;   // next execute contents

  control_decoder i_control_decoder (
    .inst (inst_d),
    .ctrl (ctrl)
  );

  assign rs_d = inst_d.r.rs;
  assign rt_d = inst_d.r.rt;

  always_comb begin
    if (ctrl.link)
      imm_ext = 32'd8;                                      // link offset for jal
    else if (ctrl.imm_zero_ext)
      imm_ext = {16'h0000, inst_d.i.imm};
    else
      imm_ext = {{16{inst_d.i.imm[15]}}, inst_d.i.imm};
  end

  always_comb begin
    id_ex_d.ctrl      = ctrl;
    id_ex_d.pc_plus_4 = pc_d + 32'd4;
    id_ex_d.op_a      = rd_data_a;
    id_ex_d.op_b      = rd_data_b;
    id_ex_d.inst_lo   = inst_d.j.idx;
    id_ex_d.imm       = imm_ext;
    id_ex_d.br_off    = {{14{inst_d.i.imm[15]}}, inst_d.i.imm, 2'b00};
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      id_ex <= '0;
    else if (flush_e)
      id_ex <= '0;          // bubble into execute
    else if (!stall_fd)
      id_ex <= id_ex_d;
  end

endmodule

// ==== source/execute_stage.sv ====
module execute_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  id_ex_t    id_ex,
  input  fwd_sel_e  fwd_a,
  input  fwd_sel_e  fwd_b,
  input  word_t     mem_fwd,
  input  mem_wb_t   wb,
  output redirect_t redirect,
  output dmem_req_t dmem_req,
  output ex_mem_t   ex_mem
);

  word_t      src_a_fwd, src_b_fwd;  // rs and rt after forwarding
  word_t      alu_a, alu_b, alu_out;
  logic [4:0] shamt;
  reg_idx_t   dst;
  logic       br_cond;
  logic [3:0] st_be;
  word_t      st_data;
  ex_mem_t    ex_mem_d;

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                    word_t wb_val);
    word_t val;
    case (sel)
      FWD_FROM_MEM: val = mem_val;
      FWD_FROM_WB:  val = wb_val;
      default:      val = reg_val;
    endcase
    return val;
  endfunction

  assign src_a_fwd = fwd_mux(fwd_a, id_ex.op_a, mem_fwd, wb.data);
  assign src_b_fwd = fwd_mux(fwd_b, id_ex.op_b, mem_fwd, wb.data);

  assign alu_a = id_ex.ctrl.alu_src_a_pc ? id_ex.pc_plus_4 - 32'd4 : src_a_fwd;
  assign alu_b = id_ex.ctrl.alu_src_b_imm ? id_ex.imm : src_b_fwd;
  assign shamt = id_ex.inst_lo[10:6];

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB:  alu_out = alu_a - alu_b;
      ALU_AND:  alu_out = alu_a & alu_b;
      ALU_OR:   alu_out = alu_a | alu_b;
      ALU_XOR:  alu_out = alu_a ^ alu_b;
      ALU_NOR:  alu_out = ~(alu_a | alu_b);
      ALU_SLT:  alu_out = {31'd0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: alu_out = {31'd0, alu_a < alu_b};
      ALU_SLL:  alu_out = alu_b << shamt;
      ALU_SRL:  alu_out = alu_b >> shamt;
      ALU_SRA:  alu_out = $signed(alu_b) >>> shamt;
      ALU_LUI:  alu_out = {alu_b[15:0], 16'h0000};
      default:  alu_out = alu_a + alu_b;
    endcase
  end

  always_comb begin
    case (id_ex.ctrl.br_type)
      BR_JR:   br_cond = 1'b1;
      BR_BEQ:  br_cond = src_a_fwd == src_b_fwd;
      BR_BNE:  br_cond = src_a_fwd != src_b_fwd;
      BR_BLEZ: br_cond = src_a_fwd[31] || src_a_fwd == '0;
      BR_BLTZ: br_cond = src_a_fwd[31];
      BR_BGEZ: br_cond = !src_a_fwd[31];
      BR_BGTZ: br_cond = !src_a_fwd[31] && src_a_fwd != '0;
      default: br_cond = 1'b0;                       // not a branch
    endcase
  end

  always_comb begin
    redirect.take = br_cond || id_ex.ctrl.jump;
    if (id_ex.ctrl.br_type == BR_JR)
      redirect.target = src_a_fwd;
    else if (id_ex.ctrl.jump)
      redirect.target = {id_ex.pc_plus_4[31:28], id_ex.inst_lo, 2'b00};
    else
      redirect.target = id_ex.pc_plus_4 + id_ex.br_off;
  end

  always_comb begin
    case (id_ex.ctrl.reg_dst)
      DST_RD:   dst = id_ex.inst_lo[15:11];
      DST_RA31: dst = 5'd31;
      default:  dst = id_ex.inst_lo[20:16];
    endcase
  end

  // little endian lanes picked by the low address bits
  always_comb begin
    case (id_ex.ctrl.mem_op)
      MEM_UBYTE, MEM_SBYTE: begin
        st_data = {4{src_b_fwd[7:0]}};
        st_be   = 4'b0001 << alu_out[1:0];
      end
      MEM_UHALF, MEM_SHALF: begin
        st_data = {2{src_b_fwd[15:0]}};
        st_be   = alu_out[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        st_data = src_b_fwd;
        st_be   = 4'b1111;
      end
    endcase
  end

  always_comb begin
    dmem_req.we    = id_ex.ctrl.write_mem;
    dmem_req.re    = id_ex.ctrl.read_mem;
    dmem_req.addr  = alu_out[31:2];
    dmem_req.be    = st_be;
    dmem_req.wdata = st_data;
  end

  always_comb begin
    ex_mem_d.write_reg = id_ex.ctrl.write_reg;
    ex_mem_d.read_mem  = id_ex.ctrl.read_mem;
    ex_mem_d.mem_op    = id_ex.ctrl.mem_op;
    ex_mem_d.dst       = dst;
    ex_mem_d.alu_out   = alu_out;
    ex_mem_d.addr_lo   = alu_out[1:0];
    ex_mem_d.st_src    = src_b_fwd;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      ex_mem <= '0;
    else
      ex_mem <= ex_mem_d;
  end

endmodule

// ==== source/mem_wb_stage.sv ====
module mem_wb_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  ex_mem_t ex_mem,
  input  word_t   dmem_rdata,
  output word_t   mem_fwd,
  output mem_wb_t wb
);

  word_t   lane;       // addressed byte or half moved to bit 0
  word_t   load_data;
  mem_wb_t wb_d;

  assign lane    = dmem_rdata >> {ex_mem.addr_lo, 3'b000};
  assign mem_fwd = ex_mem.alu_out;

  always_comb begin
    case (ex_mem.mem_op)
      MEM_UBYTE: load_data = {24'h000000, lane[7:0]};
      MEM_SBYTE: load_data = {{24{lane[7]}}, lane[7:0]};
      MEM_UHALF: load_data = {16'h0000, lane[15:0]};
      MEM_SHALF: load_data = {{16{lane[15]}}, lane[15:0]};
      default:   load_data = dmem_rdata;
    endcase
  end

  always_comb begin
    wb_d.write_reg = ex_mem.write_reg;
    wb_d.dst       = ex_mem.dst;
    wb_d.data      = ex_mem.read_mem ? load_data : ex_mem.alu_out;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      wb <= '0;
    else
      wb <= wb_d;
  end

endmodule

// ==== source/hazard_unit.sv ====
module hazard_unit import isa_pkg::*, pipe_pkg::*; (
  input  reg_idx_t rs_d,
  input  reg_idx_t rt_d,
  input  id_ex_t   id_ex,
  input  ex_mem_t  ex_mem,
  input  mem_wb_t  wb,
  output logic     stall_fd,
  output logic     flush_e,
  output fwd_sel_e fwd_a,
  output fwd_sel_e fwd_b
);

  reg_idx_t rs_e, rt_e;

  assign rs_e = id_ex.inst_lo[25:21];
  assign rt_e = id_ex.inst_lo[20:16];   // also the load destination

  // load in execute feeding decode waits one cycle
  assign stall_fd = id_ex.ctrl.read_mem && rt_e != '0 && (rt_e == rs_d || rt_e == rt_d);
  assign flush_e  = stall_fd;

  function automatic fwd_sel_e fwd_pick(reg_idx_t src, ex_mem_t mem_stage,
                                        mem_wb_t wb_stage);
    fwd_sel_e sel;
    if (mem_stage.write_reg && mem_stage.dst != '0 && mem_stage.dst == src)
      sel = FWD_FROM_MEM;               // youngest result wins
    else if (wb_stage.write_reg && wb_stage.dst != '0 && wb_stage.dst == src)
      sel = FWD_FROM_WB;
    else
      sel = FWD_NONE;
    return sel;
  endfunction

  assign fwd_a = fwd_pick(rs_e, ex_mem, wb);
  assign fwd_b = fwd_pick(rt_e, ex_mem, wb);

endmodule

// ==== source/mips_core.sv ====
module mips_core import isa_pkg::*, pipe_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  logic        clk,
  input  logic        arst_n,
  output logic [29:0] imem_addr,
  input  word_t       imem_data,
  output dmem_req_t   dmem_req,
  input  word_t       dmem_rdata
);

  inst_u     inst_d;
  word_t     pc_d;
  reg_idx_t  rs_d, rt_d;
  word_t     rd_data_a, rd_data_b;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  mem_wb_t   wb;
  word_t     mem_fwd;      // alu result in memory stage
  redirect_t redirect;
  logic      stall_fd, flush_e;
  fwd_sel_e  fwd_a, fwd_b;

  fetch_stage #(.reset_pc(reset_pc)) i_fetch (
    .clk, .arst_n, .stall_fd, .redirect, .imem_addr, .imem_data, .inst_d, .pc_d
  );

  regfile i_regfile (
    .clk, .arst_n, .rd_addr_a(rs_d), .rd_addr_b(rt_d), .rd_data_a, .rd_data_b, .wb
  );

  decode_stage i_decode (
    .clk, .arst_n, .stall_fd, .flush_e, .inst_d, .pc_d, .rs_d, .rt_d,
    .rd_data_a, .rd_data_b, .id_ex
  );

  execute_stage i_execute (
    .clk, .arst_n, .id_ex, .fwd_a, .fwd_b, .mem_fwd, .wb, .redirect, .dmem_req, .ex_mem
  );

  mem_wb_stage i_mem_wb (
    .clk, .arst_n, .ex_mem, .dmem_rdata, .mem_fwd, .wb
  );

  hazard_unit i_hazard (
    .rs_d, .rt_d, .id_ex, .ex_mem, .wb, .stall_fd, .flush_e, .fwd_a, .fwd_b
  );

endmodule

// ==== tb/tb_asm_pkg.sv ====
package tb_asm_pkg;
  import isa_pkg::*;

  typedef struct packed {
    logic [29:0] addr;    // word address
    logic [3:0]  be;
    word_t       wdata;
  } store_t;

  function automatic word_t enc_r(funct_e f, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                                  logic [4:0] sh);
    inst_u u;
    u.r.opcode = OP_SPECIAL;
    u.r.rs     = rs;
    u.r.rt     = rt;
    u.r.rd     = rd;
    u.r.shamt  = sh;
    u.r.funct  = f;
    return u;
  endfunction

  function automatic word_t enc_i(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
    inst_u u;
    u.i.opcode = op;
    u.i.rs     = rs;
    u.i.rt     = rt;
    u.i.imm    = imm;
    return u;
  endfunction

  function automatic word_t enc_j(opcode_e op, logic [25:0] idx);
    inst_u u;
    u.j.opcode = op;
    u.j.idx    = idx;
    return u;
  endfunction

  function automatic word_t xorshift32(word_t x);
    word_t s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // preset data word, mixes every address bit
  function automatic word_t fill_word(int unsigned idx);
    return (word_t'(idx) * 32'h9e37_79b1) ^ (word_t'(idx) << 19);
  endfunction

  function automatic funct_e alu_funct(int k);
    case (k)
      0:       return F_ADDU;
      1:       return F_SUBU;
      2:       return F_AND;
      3:       return F_OR;
      4:       return F_XOR;
      5:       return F_NOR;
      6:       return F_SLT;
      7:       return F_SLTU;
      8:       return F_SLL;
      9:       return F_SRL;
      default: return F_SRA;
    endcase
  endfunction

  function automatic opcode_e alu_imm_op(int k);
    case (k)
      0:       return OP_ADDIU;
      1:       return OP_SLTI;
      2:       return OP_SLTIU;
      3:       return OP_ANDI;
      4:       return OP_ORI;
      5:       return OP_XORI;
      default: return OP_LUI;
    endcase
  endfunction

  // isa result of an alu instruction, a is rs and b is rt
  function automatic word_t alu_ref(word_t inst, word_t a, word_t b);
    inst_u in;
    word_t se, ze, r;
    in = inst;
    se = {{16{in.i.imm[15]}}, in.i.imm};
    ze = {16'h0000, in.i.imm};
    r  = '0;
    case (in.r.opcode)
      OP_SPECIAL: begin
        case (in.r.funct)
          F_ADDU:  r = a + b;
          F_SUBU:  r = a - b;
          F_AND:   r = a & b;
          F_OR:    r = a | b;
          F_XOR:   r = a ^ b;
          F_NOR:   r = ~(a | b);
          F_SLT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          F_SLTU:  r = (a < b) ? 32'd1 : 32'd0;
          F_SLL:   r = b << in.r.shamt;
          F_SRL:   r = b >> in.r.shamt;
          F_SRA:   r = $signed(b) >>> in.r.shamt;  // sign fill
          default: r = '0;
        endcase
      end
      OP_ADDIU: r = a + se;
      OP_SLTI:  r = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
      OP_SLTIU: r = (a < se) ? 32'd1 : 32'd0;        // extended imm, unsigned compare
      OP_ANDI:  r = a & ze;
      OP_ORI:   r = a | ze;
      OP_XORI:  r = a ^ ze;
      OP_LUI:   r = {in.i.imm, 16'h0000};
      default:  r = '0;
    endcase
    return r;
  endfunction

  function automatic bit branch_ref(word_t inst, word_t a, word_t b);
    inst_u in;
    in = inst;
    case (in.i.opcode)
      OP_BEQ:    return a == b;
      OP_BNE:    return a != b;
      OP_BLEZ:   return $signed(a) <= 0;
      OP_BGTZ:   return $signed(a) > 0;
      OP_REGIMM: return (in.i.rt == 5'd0) ? ($signed(a) < 0) : ($signed(a) >= 0);
      default:   return 1'b0;
    endcase
  endfunction

  // little endian lane pick and extension
  function automatic word_t load_ref(opcode_e op, word_t w, logic [1:0] lane);
    logic [7:0]  b8;
    logic [15:0] h16;
    b8  = w[8*lane +: 8];
    h16 = w[16*lane[1] +: 16];
    case (op)
      OP_LB:   return {{24{b8[7]}}, b8};
      OP_LBU:  return {24'h000000, b8};
      OP_LH:   return {{16{h16[15]}}, h16};
      OP_LHU:  return {16'h0000, h16};
      default: return w;
    endcase
  endfunction

endpackage

// ==== tb/mips_tb.sv ====
module mips_tb import isa_pkg::*, pipe_pkg::*, tb_asm_pkg::*;;

  localparam word_t reset_pc_tb = 32'h0000_0100;
  localparam word_t poison_off  = 32'h0000_07fc;   // r1 relative offset of byte 0xffc

  logic        clk;
  logic        arst_n;
  logic [29:0] imem_addr;
  word_t       imem_data;
  dmem_req_t   dmem_req;
  word_t       dmem_rdata;

  word_t       imem [0:1023];
  word_t       dmem [0:1023];
  logic [29:0] imem_addr_q;    // address seen at the last edge
  dmem_req_t   dreq_q;
  store_t      exp_q [$];      // stores in program order
  int          errors, checked, timeouts;
  word_t       rng, pc, end_pc;
  logic [15:0] st_off;         // next free slot above r1

  mips_core #(.reset_pc(reset_pc_tb)) i_dut (
    .clk, .arst_n, .imem_addr, .imem_data, .dmem_req, .dmem_rdata
  );

  always #20 clk = ~clk;

  // one cycle read latency with data presented on the falling edge
  always @(posedge clk) begin
    imem_addr_q <= imem_addr;
    dreq_q      <= dmem_req;
    if (dmem_req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_req.be[b])
          dmem[dmem_req.addr[9:0]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
      end
    end
  end

  always @(negedge clk) begin
    imem_data <= imem[imem_addr_q[9:0]];
    if (dreq_q.re)
      dmem_rdata <= dmem[dreq_q.addr[9:0]];
    else
      dmem_rdata <= ~dmem[dreq_q.addr[9:0]];   // bus junk without a read strobe
  end

  task automatic check_store();
    store_t e;
    assert (exp_q.size() != 0) else begin
      errors++;
      $display("store to byte address %h was not expected", {dmem_req.addr, 2'b00});
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      checked++;
      assert (dmem_req.addr == e.addr) else begin
        errors++;
        $display("ERROR dmem_req.addr got %h exp %h", dmem_req.addr, e.addr);
      end
      assert (dmem_req.be == e.be) else begin
        errors++;
        $display("ERROR dmem_req.be got %h exp %h", dmem_req.be, e.be);
      end
      assert (dmem_req.wdata == e.wdata) else begin
        errors++;
        $display("ERROR dmem_req.wdata got %h exp %h", dmem_req.wdata, e.wdata);
      end
    end
  endtask

  // sample mid low phase away from both edges
  always begin
    @(negedge clk);
    #5;
    if (arst_n === 1'b0) begin
      assert (dmem_req.we === 1'b0) else begin
        errors++;
        $display("ERROR dmem_req.we got %h exp %h", dmem_req.we, 1'b0);
      end
      assert (dmem_req.re === 1'b0) else begin
        errors++;
        $display("ERROR dmem_req.re got %h exp %h", dmem_req.re, 1'b0);
      end
    end else if (dmem_req.we === 1'b1) begin
      check_store();
    end
  end

  task automatic emit(word_t w);
    imem[pc[11:2]] = w;
    pc += 32'd4;
  endtask

  task automatic li(reg_idx_t rd, word_t v);
    emit(enc_i(OP_LUI, 5'd0, rd, v[31:16]));
    emit(enc_i(OP_ORI, rd, rd, v[15:0]));
  endtask

  task automatic push_store(logic [15:0] off, logic [3:0] be, word_t data);
    store_t s;
    word_t  ba;
    ba      = 32'h800 + {16'h0000, off};
    s.addr  = ba[31:2];
    s.be    = be;
    s.wdata = data;
    exp_q.push_back(s);
  endtask

  task automatic expect_sw(reg_idx_t rt, word_t v);
    emit(enc_i(OP_SW, 5'd1, rt, st_off));
    push_store(st_off, 4'hf, v);
    st_off += 16'd4;
  endtask

  task automatic poison_sw(reg_idx_t rt);
    emit(enc_i(OP_SW, 5'd1, rt, poison_off[15:0]));  // must never reach memory
  endtask

  task automatic alu_cases();
    word_t a, b, inst, expv;
    int    d;
    for (int round = 0; round < 3; round++) begin
      for (int k = 0; k < 18; k++) begin
        rng = xorshift32(rng);
        a   = rng;
        rng = xorshift32(rng);
        b   = rng;
        li(5'd4, a);
        li(5'd5, b);
        if (k < 11)
          inst = enc_r(alu_funct(k), 5'd6, 5'd4, 5'd5, a[4:0]);
        else
          inst = enc_i(alu_imm_op(k - 11), 5'd4, 5'd6, b[15:0]);
        expv = alu_ref(inst, a, b);
        d    = (k + round) % 3 + 1;          // consumer distance
        emit(inst);
        repeat (d - 1) emit(32'h0);
        expect_sw(5'd6, expv);
      end
    end
  endtask

  task automatic load_cases();
    opcode_e    op;
    logic [1:0] lane;
    word_t      v;
    li(5'd2, 32'h400);                          // preset data at word 256
    for (int i = 0; i < 13; i++) begin
      case (i)
        0:          op = OP_LW;
        1, 2:       op = OP_LH;
        3, 4:       op = OP_LHU;
        5, 6, 7, 8: op = OP_LB;
        default:    op = OP_LBU;
      endcase
      if (op == OP_LW)
        lane = 2'd0;
      else if (op == OP_LH || op == OP_LHU)
        lane = {~i[0], 1'b0};
      else
        lane = 2'(i - 5);
      v = load_ref(op, fill_word(256 + i), lane);
      emit(enc_i(op, 5'd2, 5'd7, 16'(4 * i) + 16'(lane)));
      if (i[0]) begin
        expect_sw(5'd7, v);                    // store data needs the load
      end else begin
        emit(enc_r(F_ADDU, 5'd8, 5'd7, 5'd0, 5'd0));
        expect_sw(5'd8, v);
      end
    end
  endtask

  task automatic store_cases();
    word_t v;
    rng = xorshift32(rng);
    v   = rng;
    li(5'd9, v);
    for (int lane = 0; lane < 4; lane++) begin
      emit(enc_i(OP_SB, 5'd1, 5'd9, st_off + 16'(lane)));
      push_store(st_off, 4'b0001 << lane, {4{v[7:0]}});
      st_off += 16'd4;
    end
    for (int lane = 0; lane < 4; lane += 2) begin
      emit(enc_i(OP_SH, 5'd1, 5'd9, st_off + 16'(lane)));
      push_store(st_off, 4'b0011 << lane, {2{v[15:0]}});
      st_off += 16'd4;
    end
    expect_sw(5'd9, v);
  endtask

  task automatic branch_case(opcode_e op, reg_idx_t rt_code, bit want);
    word_t a, b, ca, cb, inst;
    bit    found;
    rng   = xorshift32(rng);
    a     = '0;
    b     = '0;
    found = 1'b0;
    inst  = enc_i(op, 5'd10, (op == OP_BEQ || op == OP_BNE) ? 5'd11 : rt_code, 16'd2);
    for (int i = 0; i < 3; i++) begin
      case (i)
        0:       ca = rng | 32'h8000_0000;          // negative
        1:       ca = 32'h0;
        default: ca = (rng & 32'h7fff_ffff) | 32'h1; // positive
      endcase
      cb = (i == 1) ? ca : ca ^ 32'h1;
      if (!found && branch_ref(inst, ca, cb) == want) begin
        a     = ca;
        b     = cb;
        found = 1'b1;
      end
    end
    li(5'd10, a);
    li(5'd11, b);
    emit(inst);
    expect_sw(5'd10, a);                          // delay slot
    if (want)
      poison_sw(5'd11);
    else
      expect_sw(5'd11, b);
    expect_sw(5'd11, b);                          // target
  endtask

  task automatic jump_cases();
    word_t v, tgt, link;
    rng = xorshift32(rng);
    v   = rng;
    li(5'd10, v);
    tgt = pc + 32'd12;
    emit(enc_j(OP_J, tgt[27:2]));
    expect_sw(5'd10, v);
    poison_sw(5'd10);
    expect_sw(5'd10, v);
    tgt  = pc + 32'd12;
    link = pc + 32'd8;                            // past the delay slot
    emit(enc_j(OP_JAL, tgt[27:2]));
    expect_sw(5'd10, v);
    poison_sw(5'd10);
    expect_sw(5'd31, link);
    tgt = pc + 32'd20;                            // li, jr, slot, skipped word
    li(5'd15, tgt);
    emit(enc_r(F_JR, 5'd0, 5'd15, 5'd0, 5'd0));
    expect_sw(5'd10, v);
    poison_sw(5'd10);
    expect_sw(5'd15, tgt);
  endtask

  task automatic build_program();
    li(5'd1, 32'h800);                            // store area base
    alu_cases();
    load_cases();
    store_cases();
    for (int w = 0; w < 2; w++) begin
      branch_case(OP_BEQ, 5'd0, w[0]);
      branch_case(OP_BNE, 5'd0, w[0]);
      branch_case(OP_BLEZ, 5'd0, w[0]);
      branch_case(OP_BGTZ, 5'd0, w[0]);
      branch_case(OP_REGIMM, RT_BLTZ, w[0]);
      branch_case(OP_REGIMM, RT_BGEZ, w[0]);
    end
    jump_cases();
    end_pc = pc;
    emit(enc_j(OP_J, end_pc[27:2]));            // park here
    emit(32'h0);
  endtask

  task automatic wait_stores();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 5000) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("timed out with %0d expected stores never seen", exp_q.size());
    end
  endtask

  task automatic wait_parked();
    int n;
    n = 0;
    while (imem_addr != end_pc[31:2] && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (imem_addr != end_pc[31:2]) begin
      timeouts++;
      $display("timed out before the program reached its final self jump");
    end
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    imem_data  = '0;
    dmem_rdata = '0;
    errors     = 0;
    checked    = 0;
    timeouts   = 0;
    rng        = 32'd25;
    pc         = reset_pc_tb;
    st_off     = '0;
    for (int i = 0; i < 1024; i++) begin
      imem[i] = '0;
      dmem[i] = fill_word(i);
    end
    build_program();
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    #10;
    assert (imem_addr == reset_pc_tb[31:2]) else begin
      errors++;
      $display("ERROR imem_addr got %h exp %h", imem_addr, reset_pc_tb[31:2]);
    end
    assert (dmem_req.we == 1'b0) else begin
      errors++;
      $display("ERROR dmem_req.we got %h exp %h", dmem_req.we, 1'b0);
    end
    assert (dmem_req.re == 1'b0) else begin
      errors++;
      $display("ERROR dmem_req.re got %h exp %h", dmem_req.re, 1'b0);
    end
    wait_stores();
    if (timeouts == 0)
      wait_parked();
    $display("errors %0d, stores checked %0d, stores missing %0d, timeouts %0d",
             errors, checked, exp_q.size(), timeouts);
    if (errors == 0 && timeouts == 0 && exp_q.size() == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== build.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_stage.sv
source/regfile.sv
source/control_decoder.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/hazard_unit.sv
source/mips_core.sv
tb/tb_asm_pkg.sv
tb/mips_tb.sv
